//--- list.f
rtl/peri_pkg.sv
rtl/peri_bus_if.sv
rtl/peri_decoder.sv
rtl/peri_timer.sv
rtl/peri_gpio.sv
rtl/peri_irc.sv
rtl/peri_subsystem.sv
tb/peri_assertions.sv
tb/tb_clock_gen.sv
tb/peri_subsystem_tb.sv

//--- tb/peri_subsystem_tb.sv
// table-driven testbench for the peripheral subsystem with compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module peri_subsystem_tb import peri_pkg::*; ();

	localparam int GPIO_WIDTH = 4;
	localparam int ACK_LIMIT  = 8;
	localparam int TIMER_N    = 5;

	// byte addresses
	localparam logic [31:0] A_IRC_EN   = 32'hf000_0000;
	localparam logic [31:0] A_IRC_PEND = 32'hf000_0004;
	localparam logic [31:0] A_TMR_CTRL = 32'hf100_0000;
	localparam logic [31:0] A_TMR_CMP  = 32'hf100_0004;
	localparam logic [31:0] A_TMR_CNT  = 32'hf100_000c;
	localparam logic [31:0] A_GA_DIR   = 32'hf300_0000;
	localparam logic [31:0] A_GA_OUT   = 32'hf300_0004;
	localparam logic [31:0] A_GA_IN    = 32'hf300_0008;
	localparam logic [31:0] A_GB_DIR   = 32'hf300_0100;
	localparam logic [31:0] A_GB_OUT   = 32'hf300_0104;
	localparam logic [31:0] A_GB_IN    = 32'hf300_0108;
	localparam logic [31:0] A_NONE_LO  = 32'h2000_0000;
	localparam logic [31:0] A_NONE_HI  = 32'hf400_0004;

	typedef enum int {OP_WR, OP_RD, OP_RDMAX, OP_WAIT, OP_PINS} op_e;

	// pins check packs {b_oe, b_o, a_oe, a_o} into exp[15:0]
	typedef struct {
		op_e                   op;
		addr_t                 adr;
		sel_t                  sel;
		data_t                 wdat;
		data_t                 exp;
		logic [GPIO_WIDTH-1:0] pin_a;
		logic [GPIO_WIDTH-1:0] pin_b;
		logic [1:0]            ext;
		int                    cycles;
		logic                  exp_irq;
	} entry_t;

	logic                  clk;
	logic                  reset;
	logic                  stb_i;
	logic                  we_i;
	addr_t                 adr_i;
	sel_t                  sel_i;
	data_t                 dat_i;
	data_t                 dat_o;
	logic                  ack_o;
	logic [GPIO_WIDTH-1:0] gpio_a_i;
	logic [GPIO_WIDTH-1:0] gpio_a_o;
	logic [GPIO_WIDTH-1:0] gpio_a_oe_o;
	logic [GPIO_WIDTH-1:0] gpio_b_i;
	logic [GPIO_WIDTH-1:0] gpio_b_o;
	logic [GPIO_WIDTH-1:0] gpio_b_oe_o;
	logic [1:0]            irq_ext_i;
	logic                  irq_o;

	entry_t                steps[$];
	logic [GPIO_WIDTH-1:0] cur_pin;
	logic [GPIO_WIDTH-1:0] cur_pin_b;
	logic [1:0]            cur_ext;
	logic                  cur_irq;
	int                    cur_step = 0;
	int                    cycle_cnt = 0;
	int                    cycle_limit = 0;
	int                    data_errs = 0;
	int                    irq_errs = 0;
	int                    pin_errs = 0;
	int                    ack_errs = 0;

	tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(5)) u_clock_gen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	peri_subsystem #(.GPIO_WIDTH(GPIO_WIDTH), .IRQ_NUM(3)) DUT (
		.clk         (clk),
		.reset       (reset),
		.stb_i       (stb_i),
		.we_i        (we_i),
		.adr_i       (adr_i),
		.sel_i       (sel_i),
		.dat_i       (dat_i),
		.dat_o       (dat_o),
		.ack_o       (ack_o),
		.gpio_a_i    (gpio_a_i),
		.gpio_a_o    (gpio_a_o),
		.gpio_a_oe_o (gpio_a_oe_o),
		.gpio_b_i    (gpio_b_i),
		.gpio_b_o    (gpio_b_o),
		.gpio_b_oe_o (gpio_b_oe_o),
		.irq_ext_i   (irq_ext_i),
		.irq_o       (irq_o)
	);

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------

	task automatic check_data(string name, data_t got, data_t exp);
		if (got !== exp) begin
			$display("[ERROR] step %0d %s: got %h, expected %h", cur_step, name, got, exp);
			data_errs++;
		end
	endtask

	task automatic check_max(string name, data_t got, data_t limit);
		if ($isunknown(got) || got > limit) begin
			$display("[ERROR] step %0d %s: got %h, expected at most %h", cur_step, name, got, limit);
			data_errs++;
		end
	endtask

	task automatic check_irq(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[ERROR] step %0d %s: got %h, expected %h", cur_step, name, got, exp);
			irq_errs++;
		end
	endtask

	task automatic check_pins(string name, logic [GPIO_WIDTH-1:0] got,
			logic [GPIO_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] step %0d %s: got %h, expected %h", cur_step, name, got, exp);
			pin_errs++;
		end
	endtask

	// ------------------------------------------------------------------------
	// table building
	// ------------------------------------------------------------------------

	function automatic void push_step(op_e op, logic [31:0] badr, sel_t sel, data_t wdat,
			data_t exp, int cycles);
		entry_t e;
		e.op      = op;
		e.adr     = badr[31:2];
		e.sel     = sel;
		e.wdat    = wdat;
		e.exp     = exp;
		e.pin_a   = cur_pin;
		e.pin_b   = cur_pin_b;
		e.ext     = cur_ext;
		e.cycles  = cycles;
		e.exp_irq = cur_irq;
		steps.push_back(e);
	endfunction

	function automatic void write_step(logic [31:0] badr, data_t wdat, sel_t sel);
		push_step(OP_WR, badr, sel, wdat, '0, 0);
	endfunction

	function automatic void read_step(logic [31:0] badr, data_t exp);
		push_step(OP_RD, badr, 4'hf, '0, exp, 0);
	endfunction

	function automatic void idle_step(int cycles);
		push_step(OP_WAIT, '0, '0, '0, '0, cycles);
	endfunction

	// ------------------------------------------------------------------------
	// table execution
	// ------------------------------------------------------------------------

	// each step starts on a rising edge
	task automatic run_step(entry_t e);
		data_t rdata;
		logic  acked;
		int    waited;
		@(posedge clk);
		gpio_a_i  <= e.pin_a;
		gpio_b_i  <= e.pin_b;
		irq_ext_i <= e.ext;
		if (e.op == OP_WAIT) begin
			repeat (e.cycles - 1) @(posedge clk);
		end else if (e.op != OP_PINS) begin
			stb_i  <= 1'b1;
			we_i   <= (e.op == OP_WR);
			adr_i  <= e.adr;
			sel_i  <= e.sel;
			dat_i  <= e.wdat;
			acked  = 1'b0;
			waited = 0;
			rdata  = '0;
			while (!acked && waited < ACK_LIMIT) begin
				@(negedge clk);
				if (ack_o === 1'b1) begin
					acked = 1'b1;
					rdata = dat_o;
				end
				waited++;
			end
			@(posedge clk);
			stb_i <= 1'b0;
			we_i  <= 1'b0;
			if (!acked) begin
				$display("step %0d: no acknowledge from address %h within %0d cycles",
					cur_step, {e.adr, 2'b00}, ACK_LIMIT);
				ack_errs++;
			end else if (e.op == OP_RD) begin
				check_data("dat_o", rdata, e.exp);
			end else if (e.op == OP_RDMAX) begin
				check_max("dat_o", rdata, e.exp);
			end
		end
		@(negedge clk);
		check_irq("irq_o", irq_o, e.exp_irq);
		if (e.op == OP_PINS) begin
			check_pins("gpio_a_o", gpio_a_o, e.exp[3:0]);
			check_pins("gpio_a_oe_o", gpio_a_oe_o, e.exp[7:4]);
			check_pins("gpio_b_o", gpio_b_o, e.exp[11:8]);
			check_pins("gpio_b_oe_o", gpio_b_oe_o, e.exp[15:12]);
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		int    seed;
		int    wait_sum;
		int    total;
		data_t r_cmp;
		data_t r_part;
		data_t r_adir;
		data_t r_aout;
		data_t r_bdir;
		data_t r_bout;
		data_t r_en;
		data_t cmp_exp;
		stb_i     = 1'b0;
		we_i      = 1'b0;
		adr_i     = '0;
		sel_i     = '0;
		dat_i     = '0;
		gpio_a_i  = '0;
		gpio_b_i  = '0;
		irq_ext_i = '0;
		cur_pin   = '0;
		cur_pin_b = '0;
		cur_ext   = '0;
		cur_irq   = 1'b0;
		seed      = 64701;
		r_cmp     = $random(seed);
		r_part    = $random(seed);
		r_adir    = $random(seed);
		r_aout    = $random(seed);
		r_bdir    = $random(seed);
		r_bout    = $random(seed);
		r_en      = $random(seed);
		cmp_exp   = (r_cmp & 32'hff00_ff00) | (r_part & 32'h00ff_00ff);

		// register read-back with partial byte enables
		write_step(A_TMR_CMP, r_cmp, 4'hf);
		read_step(A_TMR_CMP, r_cmp);
		write_step(A_TMR_CMP, r_part, 4'b0101);
		read_step(A_TMR_CMP, cmp_exp);
		write_step(A_GA_DIR, r_adir, 4'hf);
		read_step(A_GA_DIR, r_adir & 32'hf);
		write_step(A_GA_DIR, 32'hffff_ffff, 4'b1110);
		read_step(A_GA_DIR, r_adir & 32'hf);
		write_step(A_GA_OUT, r_aout, 4'hf);
		read_step(A_GA_OUT, r_aout & 32'hf);
		write_step(A_GB_DIR, r_bdir, 4'hf);
		read_step(A_GB_DIR, r_bdir & 32'hf);
		write_step(A_GB_OUT, r_bout, 4'hf);
		read_step(A_GB_OUT, r_bout & 32'hf);
		write_step(A_IRC_EN, r_en, 4'hf);
		read_step(A_IRC_EN, r_en & 32'h7);
		write_step(A_IRC_EN, 32'h0, 4'hf);
		push_step(OP_PINS, '0, '0, '0,
			{16'h0, r_bdir[3:0], r_bout[3:0], r_adir[3:0], r_aout[3:0]}, 0);

		// unmapped pages and port isolation
		read_step(A_NONE_LO, 32'h0);
		write_step(A_NONE_HI, 32'hffff_ffff, 4'hf);
		read_step(A_NONE_HI, 32'h0);
		read_step(A_TMR_CMP, cmp_exp);
		read_step(A_GA_DIR, r_adir & 32'hf);
		read_step(A_GA_OUT, r_aout & 32'hf);
		read_step(A_GB_OUT, r_bout & 32'hf);
		read_step(A_IRC_EN, 32'h0);
		write_step(A_GA_OUT, 32'ha, 4'hf);
		read_step(A_GB_OUT, r_bout & 32'hf);
		read_step(A_GB_DIR, r_bdir & 32'hf);

		// gpio outputs and synchronised inputs
		write_step(A_GA_DIR, 32'hf, 4'hf);
		write_step(A_GA_OUT, 32'h5, 4'hf);
		push_step(OP_PINS, '0, '0, '0, {16'h0, r_bdir[3:0], r_bout[3:0], 4'hf, 4'h5}, 0);
		cur_pin   = 4'h9;
		cur_pin_b = 4'hc;
		idle_step(3);
		read_step(A_GA_IN, 32'h9);
		read_step(A_GB_IN, 32'hc);
		cur_pin = 4'h6;
		idle_step(3);
		read_step(A_GA_IN, 32'h6);
		read_step(A_GB_IN, 32'hc);
		cur_pin   = 4'h0;
		cur_pin_b = 4'h0;

		// timer sets pending bit 0 while enables stay clear
		write_step(A_TMR_CMP, TIMER_N, 4'hf);
		write_step(A_TMR_CTRL, 32'h1, 4'hf);
		read_step(A_TMR_CTRL, 32'h1);
		idle_step(20);
		read_step(A_IRC_PEND, 32'h1);
		write_step(A_TMR_CTRL, 32'h0, 4'hf);
		push_step(OP_RDMAX, A_TMR_CNT, 4'hf, '0, TIMER_N, 0);
		write_step(A_IRC_PEND, 32'h7, 4'hf);
		read_step(A_IRC_PEND, 32'h0);

		// enabled external source raises irq_o until cleared
		write_step(A_IRC_EN, 32'h2, 4'hf);
		cur_ext = 2'b01;
		idle_step(1);
		cur_ext = 2'b00;
		cur_irq = 1'b1;
		idle_step(2);
		read_step(A_IRC_PEND, 32'h2);
		cur_irq = 1'b0;
		write_step(A_IRC_PEND, 32'h2, 4'hf);
		read_step(A_IRC_PEND, 32'h0);

		// masked source stays pending without a request
		cur_ext = 2'b10;
		idle_step(1);
		cur_ext = 2'b00;
		idle_step(3);
		read_step(A_IRC_PEND, 32'h4);
		write_step(A_IRC_PEND, 32'h4, 4'hf);
		write_step(A_IRC_EN, 32'h0, 4'hf);

		wait_sum = 0;
		foreach (steps[i]) begin
			if (steps[i].op == OP_WAIT) begin
				wait_sum += steps[i].cycles;
			end
		end
		cycle_limit = steps.size() * 8 + wait_sum + 50;

		@(negedge reset);
		foreach (steps[i]) begin
			cur_step = i;
			run_step(steps[i]);
		end

		total = data_errs + irq_errs + pin_errs + ack_errs + DUT.u_assertions.err_count;
		$display("errors: data %0d, irq %0d, pins %0d, ack %0d, assertions %0d",
			data_errs, irq_errs, pin_errs, ack_errs, DUT.u_assertions.err_count);
		if (total == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// clock and synchronous reset generator for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS    = 4.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// released on a rising edge, like any other synchronous input
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/peri_assertions.sv
// bus handshake and interrupt mask assertions, bound into the subsystem top
`timescale 1ns/1ps
`default_nettype none

module peri_assertions #(
	parameter int IRQ_NUM = 3
) (
	input wire               clk,
	input wire               reset,
	input wire               stb_i,
	input wire               ack_i,
	input wire               irq_i,
	input wire [IRQ_NUM-1:0] enable_i
);

	int err_count = 0;

	// ack is a single-cycle pulse
	ack_pulse: assert property (@(posedge clk) disable iff (reset) ack_i |=> !ack_i)
		else begin
			$error("ack_o high for two cycles in a row");
			err_count++;
		end

	ack_needs_stb: assert property (@(posedge clk) disable iff (reset) $rose(ack_i) |-> stb_i)
		else begin
			$error("ack_o rose without stb_i");
			err_count++;
		end

	// irq_o is registered, so it lags the enables by one clock
	masked_irq: assert property (@(posedge clk) disable iff (reset) (enable_i == '0) |=> !irq_i)
		else begin
			$error("irq_o high while all enables were clear");
			err_count++;
		end

endmodule

bind peri_subsystem peri_assertions #(.IRQ_NUM(IRQ_NUM)) u_assertions (
	.clk      (clk),
	.reset    (reset),
	.stb_i    (stb_i),
	.ack_i    (ack_o),
	.irq_i    (irq_o),
	.enable_i (u_irc.enable_q)
);

`default_nettype wire

//--- rtl/peri_subsystem.sv
// peripheral subsystem top with decoder, timer, two GPIO ports and interrupt controller
`timescale 1ns/1ps
`default_nettype none

module peri_subsystem import peri_pkg::*; #(
	parameter int GPIO_WIDTH = 4,
	parameter int IRQ_NUM    = 3
) (
	input  wire                   clk,
	input  wire                   reset,
	// peripheral bus from the external master
	input  wire                   stb_i,
	input  wire                   we_i,
	input  wire  addr_t           adr_i,
	input  wire  sel_t            sel_i,
	input  wire  data_t           dat_i,
	output data_t                 dat_o,
	output logic                  ack_o,
	// gpio ports
	input  wire  [GPIO_WIDTH-1:0] gpio_a_i,
	output logic [GPIO_WIDTH-1:0] gpio_a_o,
	output logic [GPIO_WIDTH-1:0] gpio_a_oe_o,
	input  wire  [GPIO_WIDTH-1:0] gpio_b_i,
	output logic [GPIO_WIDTH-1:0] gpio_b_o,
	output logic [GPIO_WIDTH-1:0] gpio_b_oe_o,
	// interrupts
	input  wire  [IRQ_NUM-2:0]    irq_ext_i,
	output logic                  irq_o
);

	logic               timer_irq;
	logic [IRQ_NUM-1:0] irq_src;

	peri_bus_if irc ();
	peri_bus_if timer ();
	peri_bus_if gpio_a ();
	peri_bus_if gpio_b ();

	// source 0 is the timer, the rest are external
	assign irq_src = {irq_ext_i, timer_irq};

	peri_decoder u_decoder (
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.we_i       (we_i),
		.sel_i      (sel_i),
		.stb_i      (stb_i),
		.dat_o      (dat_o),
		.ack_o      (ack_o),
		.irc_bus    (irc.master),
		.timer_bus  (timer.master),
		.gpio_a_bus (gpio_a.master),
		.gpio_b_bus (gpio_b.master)
	);

	peri_timer u_timer (
		.clk   (clk),
		.reset (reset),
		.bus   (timer.slave),
		.irq_o (timer_irq)
	);

	peri_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio_a (
		.clk      (clk),
		.reset    (reset),
		.bus      (gpio_a.slave),
		.pin_i    (gpio_a_i),
		.pin_o    (gpio_a_o),
		.pin_oe_o (gpio_a_oe_o)
	);

	peri_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio_b (
		.clk      (clk),
		.reset    (reset),
		.bus      (gpio_b.slave),
		.pin_i    (gpio_b_i),
		.pin_o    (gpio_b_o),
		.pin_oe_o (gpio_b_oe_o)
	);

	peri_irc #(.IRQ_NUM(IRQ_NUM)) u_irc (
		.clk       (clk),
		.reset     (reset),
		.bus       (irc.slave),
		.irq_src_i (irq_src),
		.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

//--- rtl/peri_irc.sv
// interrupt controller with pending and enable registers and one CPU request
`timescale 1ns/1ps
`default_nettype none

module peri_irc import peri_pkg::*; #(
	parameter int IRQ_NUM = 3
) (
	input  wire                clk,
	input  wire                reset,
	peri_bus_if.slave          bus,
	input  wire  [IRQ_NUM-1:0] irq_src_i,
	output logic               irq_o
);

	reg_ofs_t           ofs;
	logic               wr_en;
	logic [IRQ_NUM-1:0] enable_q;
	logic [IRQ_NUM-1:0] pending_q;
	logic [IRQ_NUM-1:0] pending_clr;
	data_t              enable_wdata;
	data_t              clr_wdata;

	assign ofs   = bus.adr[1:0];
	assign wr_en = bus.stb & ~bus.ack & bus.we;

	assign enable_wdata = merge_bytes(data_t'(enable_q), bus.dat_w, bus.sel);
	// only the written bytes can clear
	assign clr_wdata    = merge_bytes('0, bus.dat_w, bus.sel);

	assign pending_clr = (wr_en && ofs == IRC_PENDING) ? clr_wdata[IRQ_NUM-1:0] : '0;

	// ------------------------------------------------------------------------
	// bus side
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack  <= 1'b0;
			enable_q <= '0;
		end else begin
			bus.ack <= bus.stb & ~bus.ack;
			if (wr_en && ofs == IRC_ENABLE) begin
				enable_q <= enable_wdata[IRQ_NUM-1:0];
			end
		end
	end

	always_comb begin
		case (ofs)
			IRC_ENABLE:  bus.dat_r = data_t'(enable_q);
			IRC_PENDING: bus.dat_r = data_t'(pending_q);
			default:     bus.dat_r = '0;
		endcase
	end

	// ------------------------------------------------------------------------
	// pending bits and request
	// ------------------------------------------------------------------------

	// a new pulse beats a clear in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			pending_q <= '0;
			irq_o     <= 1'b0;
		end else begin
			pending_q <= (pending_q & ~pending_clr) | irq_src_i;
			irq_o     <= |(pending_q & enable_q);
		end
	end

endmodule

`default_nettype wire

//--- rtl/peri_gpio.sv
// GPIO port with direction and output registers and synchronised pin inputs
`timescale 1ns/1ps
`default_nettype none

module peri_gpio import peri_pkg::*; #(
	parameter int GPIO_WIDTH = 4
) (
	input  wire                   clk,
	input  wire                   reset,
	peri_bus_if.slave             bus,
	input  wire  [GPIO_WIDTH-1:0] pin_i,
	output logic [GPIO_WIDTH-1:0] pin_o,
	output logic [GPIO_WIDTH-1:0] pin_oe_o
);

	reg_ofs_t              ofs;
	logic                  wr_en;
	logic [GPIO_WIDTH-1:0] dir_q;
	logic [GPIO_WIDTH-1:0] out_q;
	logic [GPIO_WIDTH-1:0] pin_meta;
	logic [GPIO_WIDTH-1:0] pin_sync;
	data_t                 dir_wdata;
	data_t                 out_wdata;

	assign ofs   = bus.adr[1:0];
	assign wr_en = bus.stb & ~bus.ack & bus.we;

	assign dir_wdata = merge_bytes(data_t'(dir_q), bus.dat_w, bus.sel);
	assign out_wdata = merge_bytes(data_t'(out_q), bus.dat_w, bus.sel);

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack <= 1'b0;
			dir_q   <= '0;
			out_q   <= '0;
		end else begin
			bus.ack <= bus.stb & ~bus.ack;
			if (wr_en && ofs == GPIO_DIR) begin
				dir_q <= dir_wdata[GPIO_WIDTH-1:0];
			end
			if (wr_en && ofs == GPIO_OUT) begin
				out_q <= out_wdata[GPIO_WIDTH-1:0];
			end
		end
	end

	// two-flop synchroniser on the pins
	always_ff @(posedge clk) begin
		pin_meta <= pin_i;
		pin_sync <= pin_meta;
	end

	// a set direction bit makes the pin an output
	assign pin_oe_o = dir_q;
	assign pin_o    = out_q;

	always_comb begin
		case (ofs)
			GPIO_DIR: bus.dat_r = data_t'(dir_q);
			GPIO_OUT: bus.dat_r = data_t'(out_q);
			GPIO_IN:  bus.dat_r = data_t'(pin_sync);
			default:  bus.dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/peri_timer.sv
// interval timer with enable, compare register, counter and interrupt pulse
`timescale 1ns/1ps
`default_nettype none

module peri_timer import peri_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	peri_bus_if.slave  bus,
	output logic       irq_o
);

	reg_ofs_t ofs;
	logic     wr_en;
	logic     enable_q;
	data_t    compare_q;
	data_t    count_q;
	data_t    ctrl_wdata;
	data_t    compare_wdata;

	assign ofs   = bus.adr[1:0];
	assign wr_en = bus.stb & ~bus.ack & bus.we;

	assign ctrl_wdata    = merge_bytes({31'd0, enable_q}, bus.dat_w, bus.sel);
	assign compare_wdata = merge_bytes(compare_q, bus.dat_w, bus.sel);

	// one-cycle ack pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= bus.stb & ~bus.ack;
		end
	end

	// register writes, count is read only
	always_ff @(posedge clk) begin
		if (reset) begin
			enable_q  <= 1'b0;
			compare_q <= '0;
		end else if (wr_en) begin
			case (ofs)
				TIMER_CTRL:    enable_q  <= ctrl_wdata[0];
				TIMER_COMPARE: compare_q <= compare_wdata;
				default:       ;
			endcase
		end
	end

	// wrap on compare match and pulse the interrupt
	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
			irq_o   <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (enable_q) begin
				if (count_q == compare_q) begin
					count_q <= '0;
					irq_o   <= 1'b1;
				end else begin
					count_q <= count_q + 1'b1;
				end
			end
		end
	end

	always_comb begin
		case (ofs)
			TIMER_CTRL:    bus.dat_r = {31'd0, enable_q};
			TIMER_COMPARE: bus.dat_r = compare_q;
			TIMER_COUNT:   bus.dat_r = count_q;
			default:       bus.dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/peri_decoder.sv
// peripheral bus address decoder with read data and acknowledge multiplexer
`timescale 1ns/1ps
`default_nettype none

module peri_decoder import peri_pkg::*; (
	input  wire addr_t     adr_i,
	input  wire data_t     dat_i,
	input  wire            we_i,
	input  wire sel_t      sel_i,
	input  wire            stb_i,
	output data_t          dat_o,
	output logic           ack_o,
	peri_bus_if.master     irc_bus,
	peri_bus_if.master     timer_bus,
	peri_bus_if.master     gpio_a_bus,
	peri_bus_if.master     gpio_b_bus
);

	logic irc_hit;
	logic timer_hit;
	logic gpio_a_hit;
	logic gpio_b_hit;

	// adr_i[29:22] is byte address 31:24, adr_i[29:6] is 31:8
	assign irc_hit    = (adr_i[29:22] == IRC_PAGE);
	assign timer_hit  = (adr_i[29:22] == TIMER_PAGE);
	assign gpio_a_hit = (adr_i[29:6] == GPIO_A_PAGE);
	assign gpio_b_hit = (adr_i[29:6] == GPIO_B_PAGE);

	// ------------------------------------------------------------------------
	// request fan-out
	// ------------------------------------------------------------------------

	assign irc_bus.adr   = adr_i;
	assign irc_bus.dat_w = dat_i;
	assign irc_bus.we    = we_i;
	assign irc_bus.sel   = sel_i;
	assign irc_bus.stb   = stb_i & irc_hit;

	assign timer_bus.adr   = adr_i;
	assign timer_bus.dat_w = dat_i;
	assign timer_bus.we    = we_i;
	assign timer_bus.sel   = sel_i;
	assign timer_bus.stb   = stb_i & timer_hit;

	assign gpio_a_bus.adr   = adr_i;
	assign gpio_a_bus.dat_w = dat_i;
	assign gpio_a_bus.we    = we_i;
	assign gpio_a_bus.sel   = sel_i;
	assign gpio_a_bus.stb   = stb_i & gpio_a_hit;

	assign gpio_b_bus.adr   = adr_i;
	assign gpio_b_bus.dat_w = dat_i;
	assign gpio_b_bus.we    = we_i;
	assign gpio_b_bus.sel   = sel_i;
	assign gpio_b_bus.stb   = stb_i & gpio_b_hit;

	// ------------------------------------------------------------------------
	// response mux
	// ------------------------------------------------------------------------

	always_comb begin
		if (irc_hit) begin
			dat_o = irc_bus.dat_r;
			ack_o = irc_bus.ack;
		end else if (timer_hit) begin
			dat_o = timer_bus.dat_r;
			ack_o = timer_bus.ack;
		end else if (gpio_a_hit) begin
			dat_o = gpio_a_bus.dat_r;
			ack_o = gpio_a_bus.ack;
		end else if (gpio_b_hit) begin
			dat_o = gpio_b_bus.dat_r;
			ack_o = gpio_b_bus.ack;
		end else begin
			// unmapped, acknowledge at once with zero data
			dat_o = '0;
			ack_o = stb_i;
		end
	end

endmodule

`default_nettype wire

//--- rtl/peri_bus_if.sv
// peripheral bus interface for one slave, with master and slave modports
`timescale 1ns/1ps
`default_nettype none

interface peri_bus_if import peri_pkg::*; ();

	// request side, driven by the decoder
	addr_t adr;
	data_t dat_w;
	logic  we;
	sel_t  sel;
	logic  stb;

	// response side, driven by the slave
	data_t dat_r;
	logic  ack;

	modport master (
		output adr,
		output dat_w,
		output we,
		output sel,
		output stb,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  adr,
		input  dat_w,
		input  we,
		input  sel,
		input  stb,
		output dat_r,
		output ack
	);

endinterface

`default_nettype wire

//--- rtl/peri_pkg.sv
// peripheral bus types, address map pages, register offsets and byte-merge helper
`default_nettype none

package peri_pkg;

	// word address is byte address bits 31:2
	typedef logic [29:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  sel_t;
	typedef logic [1:0]  reg_ofs_t;

	// ------------------------------------------------------------------------
	// address map
	// ------------------------------------------------------------------------

	// compared against byte address bits 31:24
	localparam logic [7:0]  IRC_PAGE    = 8'hf0;
	localparam logic [7:0]  TIMER_PAGE  = 8'hf1;
	// compared against byte address bits 31:8
	localparam logic [23:0] GPIO_A_PAGE = 24'hf30000;
	localparam logic [23:0] GPIO_B_PAGE = 24'hf30001;

	// timer registers
	localparam reg_ofs_t TIMER_CTRL    = 2'd0;
	localparam reg_ofs_t TIMER_COMPARE = 2'd1;
	localparam reg_ofs_t TIMER_COUNT   = 2'd3;

	// gpio registers
	localparam reg_ofs_t GPIO_DIR = 2'd0;
	localparam reg_ofs_t GPIO_OUT = 2'd1;
	localparam reg_ofs_t GPIO_IN  = 2'd2;

	// interrupt controller registers
	localparam reg_ofs_t IRC_ENABLE  = 2'd0;
	localparam reg_ofs_t IRC_PENDING = 2'd1;

	// replace the bytes of old_val whose enable is set
	function automatic data_t merge_bytes(data_t old_val, data_t new_val, sel_t sel);
		data_t result;
		result = old_val;
		for (int i = 0; i < $bits(sel_t); i++) begin
			if (sel[i]) begin
				result[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return result;
	endfunction

endpackage

`default_nettype wire
